/* common/game_pkg.sv */
`default_nettype none

package game_pkg;

  // one card, shown as a single hex digit
  typedef logic [3:0] card_t;

  localparam int DECK_LEN = 11; // cards in the ring

  // display order, wraps back to 7 after the last card
  localparam card_t DECK_INIT [DECK_LEN] = '{
    4'd7, 4'd6, 4'd5, 4'd6,
    4'd2, 4'd2, 4'd3, 4'd2,
    4'd4, 4'd4, 4'd1
  };

  // turn sequencer
  // a turn is two timer periods: show the new card, then judge
  typedef enum logic [2:0] {
    st_idle        = 3'd0, // before the first start
    st_wait_first  = 3'd1, // old card shown, waiting for tick
    st_advance     = 3'd2, // one cycle, deck rotates
    st_wait_second = 3'd3, // new card shown, player answers
    st_analyse     = 3'd4, // judge works for two cycles
    st_finish      = 3'd5  // game over, held until start
  } ctrl_state_t;

endpackage

`default_nettype wire

/* common/seg_pkg.sv */
`default_nettype none

package seg_pkg;

  // active low segments, bit 0 = a ... bit 6 = g
  typedef logic [6:0] seg_t;

  // hex digit patterns, index = digit value
  localparam seg_t SEG_TABLE [16] = '{
    7'b100_0000, // 0
    7'b111_1001, // 1
    7'b010_0100, // 2
    7'b011_0000, // 3
    7'b001_1001, // 4
    7'b001_0010, // 5
    7'b000_0010, // 6
    7'b111_1000, // 7
    7'b000_0000, // 8
    7'b001_1000, // 9
    7'b000_1000, // a
    7'b000_0011, // b
    7'b100_0110, // c
    7'b010_0001, // d
    7'b000_0110, // e
    7'b000_1110  // f
  };

endpackage

`default_nettype wire

/* datapath/card_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module card_timer #(
  parameter int TICK_CYCLES = 50_000_000 // period in clock cycles
) (
  input  logic clk,
  input  logic resetn,
  output logic tick   // one cycle every TICK_CYCLES
);

  // at least one bit even for tiny periods
  localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_CYCLES - 1);

  logic [CNT_W-1:0] count;

  // free running, independent of controller state
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      count <= RELOAD;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= RELOAD; // wrap
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* datapath/card_deck.sv */
`timescale 1ns/1ps
`default_nettype none

module card_deck (
  input  logic            clk,
  input  logic            resetn,
  input  logic            advance,   // rotate by one
  output game_pkg::card_t cur_card,  // card on display
  output game_pkg::card_t prev_card  // card shown before it
);
  import game_pkg::*;

  card_t ring [DECK_LEN]; // ring[0] is the current card
  card_t prev_q;

  // deck loaded only at reset, position kept across games
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ring   <= DECK_INIT;
      prev_q <= DECK_INIT[DECK_LEN-1]; // last entry precedes the first
    end else if (advance) begin
      prev_q <= ring[0];
      for (int i = 0; i < DECK_LEN - 1; i++) begin
        ring[i] <= ring[i+1]; // next entry moves to the front
      end
      ring[DECK_LEN-1] <= ring[0]; // front wraps to the back
    end
  end

  assign cur_card  = ring[0];
  assign prev_card = prev_q;

endmodule

`default_nettype wire

/* datapath/answer_judge.sv */
`timescale 1ns/1ps
`default_nettype none

module answer_judge (
  input  logic            clk,
  input  logic            resetn,
  input  logic            advance,    // new card clears key latch
  input  logic            analyse,    // two cycle judge window
  input  logic            match_key,
  input  logic            differ_key,
  input  game_pkg::card_t cur_card,
  input  game_pkg::card_t prev_card,
  output logic            done,       // verdict valid
  output logic            mistake     // wrong or missing answer
);

  logic key_valid; // some key seen since advance
  logic key_match; // last key was match
  logic judged;    // verdict taken this analyse window
  logic same_card;

  assign same_card = (cur_card == prev_card);

  // key latch where the last key wins and match wins a tie
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      key_valid <= 1'b0;
      key_match <= 1'b0;
    end else if (advance) begin
      key_valid <= 1'b0;
    end else if (match_key || differ_key) begin
      key_valid <= 1'b1;
      key_match <= match_key;
    end
  end

  // verdict registered in the first analyse cycle
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      judged  <= 1'b0;
      mistake <= 1'b0;
    end else begin
      judged <= analyse;
      if (analyse && !judged) begin
        mistake <= !key_valid || (key_match != same_card); // held afterwards
      end
    end
  end

  assign done = analyse && judged; // second analyse cycle onward

endmodule

`default_nettype wire

/* rtl/game_control.sv */
`timescale 1ns/1ps
`default_nettype none

module game_control (
  input  logic clk,
  input  logic resetn,
  input  logic start,
  input  logic tick,      // card period pulse from timer
  input  logic done,      // verdict ready
  input  logic mistake,   // verdict, valid with done
  output logic advance,   // one cycle pulse
  output logic analyse,   // level, only in st_analyse
  output logic game_over
);
  import game_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // state register
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // next state
  always_comb begin
    state_nxt = state; // hold by default
    case (state)
      st_idle: begin
        if (start) state_nxt = st_wait_first;
      end
      st_wait_first: begin
        if (tick) state_nxt = st_advance; // old card's period over
      end
      st_advance: begin
        state_nxt = st_wait_second; // single cycle
      end
      st_wait_second: begin
        if (tick) state_nxt = st_analyse; // answer window closed
      end
      st_analyse: begin
        // verdict acted on directly
        if (done) state_nxt = mistake ? st_finish : st_wait_first;
      end
      st_finish: begin
        // ticks ignored here, resume from current deck position
        if (start) state_nxt = st_wait_first;
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // outputs decoded from state only
  assign advance   = (state == st_advance);
  assign analyse   = (state == st_analyse);
  assign game_over = (state == st_finish);

endmodule

`default_nettype wire

/* rtl/hex_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_decoder (
  input  game_pkg::card_t card,
  output seg_pkg::seg_t   segments // active low
);
  import seg_pkg::*;

  always_comb begin
    segments = '1; // blank unless the code has a pattern
    if (int'(card) < $size(SEG_TABLE)) begin
      segments = SEG_TABLE[card];
    end
  end

endmodule

`default_nettype wire

/* rtl/memory_game.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game #(
  parameter int TICK_CYCLES = 50_000_000 // clock cycles per card
) (
  input  logic          clk,
  input  logic          resetn,
  input  logic          start,      // active high level
  input  logic          match_key,
  input  logic          differ_key,
  output seg_pkg::seg_t hex0,
  output logic          game_over
);
  import game_pkg::*;

  logic  tick;                // one pulse per card period
  logic  advance;             // rotate deck, clear key latch
  logic  analyse;             // judge window, two cycles
  logic  done;
  logic  mistake;
  card_t cur_card;
  card_t prev_card;

  card_timer #(
    .TICK_CYCLES(TICK_CYCLES)
  ) u_card_timer (
    .clk   (clk),
    .resetn(resetn),
    .tick  (tick)
  );

  card_deck u_card_deck (
    .clk      (clk),
    .resetn   (resetn),
    .advance  (advance),
    .cur_card (cur_card),
    .prev_card(prev_card)
  );

  answer_judge u_answer_judge (
    .clk       (clk),
    .resetn    (resetn),
    .advance   (advance),
    .analyse   (analyse),
    .match_key (match_key),
    .differ_key(differ_key),
    .cur_card  (cur_card),
    .prev_card (prev_card),
    .done      (done),
    .mistake   (mistake)
  );

  game_control u_game_control (
    .clk      (clk),
    .resetn   (resetn),
    .start    (start),
    .tick     (tick),
    .done     (done),
    .mistake  (mistake),
    .advance  (advance),
    .analyse  (analyse),
    .game_over(game_over)
  );

  hex_decoder u_hex_decoder (
    .card    (cur_card),
    .segments(hex0) // combinational from the current card
  );

endmodule

`default_nettype wire

/* verification/memory_game_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_chk (
  input logic clk,
  input logic resetn,
  input logic start,
  input logic tick,
  input logic advance,
  input logic analyse,
  input logic game_over
);

  // card period pulse is a single cycle
  a_tick_single: assert property (@(posedge clk) disable iff (!resetn)
    tick |=> !tick)
    else $error("tick high in two consecutive cycles");

  a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
    !(advance && analyse)) // rotate and judge never together
    else $error("advance and analyse high together");

  // judge window is exactly two cycles
  a_analyse_len: assert property (@(posedge clk) disable iff (!resetn)
    $rose(analyse) |=> analyse ##1 !analyse)
    else $error("analyse did not last two cycles");

  a_over_hold: assert property (@(posedge clk) disable iff (!resetn)
    (game_over && !start) |=> game_over) // only start leaves finish
    else $error("game_over fell without start");

endmodule

bind memory_game memory_game_chk u_memory_game_chk (
  .clk      (clk),
  .resetn   (resetn),
  .start    (start),
  .tick     (tick),
  .advance  (advance),
  .analyse  (analyse),
  .game_over(game_over)
);

`default_nettype wire

/* verification/memory_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_tb;
  import game_pkg::*;
  import seg_pkg::*;

  localparam int TICK_CYCLES    = 16;
  localparam int TIMEOUT_CYCLES = 40 * 2 * TICK_CYCLES + 200; // 40 turns of two periods

  // how a turn is answered
  localparam int MODE_RIGHT = 0;
  localparam int MODE_WRONG = 1;
  localparam int MODE_NONE  = 2;
  localparam int MODE_FIX   = 3; // wrong key first then the right one

  logic        clk        = 1'b0;
  logic        resetn     = 1'b0;
  logic        start      = 1'b0;
  logic        match_key  = 1'b0;
  logic        differ_key = 1'b0;
  seg_t        hex0;
  logic        game_over;

  int          exp_pos    = 0;    // deck position the display should show
  int          tick_phase = 0;    // cycles since reset release
  int          run_cycles = 0;
  bit          check_en   = 1'b0;

  memory_game #(
    .TICK_CYCLES(TICK_CYCLES)
  ) UUT (
    .clk       (clk),
    .resetn    (resetn),
    .start     (start),
    .match_key (match_key),
    .differ_key(differ_key),
    .hex0      (hex0),
    .game_over (game_over)
  );

  always #5 clk = ~clk; // 10 ns period

  // expected segment code for a deck position
  function automatic seg_t ref_seg(input int pos);
    return SEG_TABLE[DECK_INIT[pos % DECK_LEN]];
  endfunction

  // is this key right for the card at pos against its neighbor
  function automatic bit answer_correct(input int pos, input bit pressed_match);
    card_t cur;
    card_t prev;
    cur  = DECK_INIT[pos % DECK_LEN];
    prev = DECK_INIT[(pos + DECK_LEN - 1) % DECK_LEN];
    return pressed_match == (cur == prev);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // mirrors the card timer count since reset release
  always @(posedge clk or negedge resetn) begin
    if (!resetn) tick_phase <= 0;
    else         tick_phase <= tick_phase + 1;
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= TIMEOUT_CYCLES) begin
      report_failure("run exceeded its cycle limit without finishing the tests");
    end
  end

  // checked every cycle because equal neighbors leave hex0 unchanged
  always @(negedge clk) begin
    if (check_en) begin
      assert (hex0 == ref_seg(exp_pos))
        else report_failure($sformatf("mismatch hex0: expected %h actual %h (pos %0d)",
                                      ref_seg(exp_pos), hex0, exp_pos));
    end
  end

  // returns on the edge where the FSM samples tick high
  task automatic wait_tick();
    @(posedge clk);
    while (!(tick_phase != 0 && tick_phase % TICK_CYCLES == 0)) @(posedge clk);
  endtask

  task automatic press_key(input bit use_match);
    match_key  <= use_match;
    differ_key <= !use_match;
    @(posedge clk);
    match_key  <= 1'b0; // one cycle press
    differ_key <= 1'b0;
  endtask

  task automatic press_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // one turn from the FSM waiting for its first tick
  task automatic play_turn(input int mode);
    int new_pos;
    int delay;
    bit right_match;
    wait_tick();
    @(posedge clk);
    new_pos     = exp_pos + 1;
    exp_pos    <= new_pos; // deck rotates on this edge
    right_match = answer_correct(new_pos, 1'b1);
    delay       = 1 + int'($urandom % 32'd6);
    repeat (delay) @(posedge clk);
    case (mode)
      MODE_RIGHT: press_key(right_match);
      MODE_WRONG: press_key(!right_match);
      MODE_FIX: begin
        press_key(!right_match);
        @(posedge clk);
        press_key(right_match); // last key wins
      end
      default: ; // no key this turn
    endcase
    wait_tick();            // answer window closes
    repeat (3) @(negedge clk); // two judge cycles then the FSM acts
    if (mode == MODE_RIGHT || mode == MODE_FIX) begin
      assert (!game_over) else report_failure("game_over rose after a correct answer");
    end else begin
      assert (game_over) else report_failure("game_over did not rise after a bad answer");
    end
  endtask

  task automatic hold_game_over();
    repeat (2 * TICK_CYCLES) @(posedge clk); // display must stay frozen
    @(negedge clk);
    assert (game_over) else report_failure("game_over fell before start was pressed");
  endtask

  task automatic restart_game();
    press_start();
    @(negedge clk);
    assert (!game_over) else report_failure("game_over stayed high after start");
  endtask

  initial begin
    void'($urandom(32'hcf41));
    repeat (5) @(posedge clk);
    resetn   <= 1'b1;
    check_en <= 1'b1;

    // idle without start
    @(negedge clk);
    assert (!game_over) else report_failure("game_over high after reset");
    repeat (3 * TICK_CYCLES) @(posedge clk);

    // correct play past one full wrap and then a corrected answer
    press_start();
    for (int t = 0; t < 13; t++) begin
      play_turn(MODE_RIGHT);
    end
    play_turn(MODE_FIX);

    play_turn(MODE_WRONG);
    hold_game_over();
    restart_game();

    play_turn(MODE_NONE); // silent turn loses too
    hold_game_over();
    restart_game();

    // random mix with the position carried across games
    for (int t = 0; t < 10; t++) begin
      play_turn((($urandom % 32'd2) == 0) ? MODE_RIGHT : MODE_FIX);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
common/game_pkg.sv
common/seg_pkg.sv
datapath/card_timer.sv
datapath/card_deck.sv
datapath/answer_judge.sv
rtl/game_control.sv
rtl/hex_decoder.sv
rtl/memory_game.sv
verification/memory_game_chk.sv
verification/memory_game_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = memory_game_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
